/* pkt_rx_top.f */
+incdir+src
src/pkt_stream_pkg.sv
src/pkt_csr_pkg.sv
src/axi_fifo.sv
src/rx_frame_check.sv
src/axi_packet_gate.sv
src/rx_csr_apb.sv
src/pkt_rx_top.sv
testbench/tb_pkt_rx_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the packet receive testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f pkt_rx_top.f --top-module tb_pkt_rx_top -o sim_tb

# The log decides the verdict, so a failing run must not stop the script here.
./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Verification passed" "$LOG"; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

/* src/axi_fifo.sv */
// Synchronous stream FIFO
`timescale 1ns/1ns
`include "pkt_rx_macros.svh"

module axi_fifo #(
   parameter int WIDTH = `PKT_DATA_W + 1,
   parameter int SIZE  = `PKT_FIFO_AW
) (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             o_tready,
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             i_tready
);
   import pkt_stream_pkg::*;

   localparam int            DEPTH    = 1 << SIZE;
   localparam fifo_addr_t    LAST_IDX = fifo_addr_t'(DEPTH - 1);
   localparam logic [SIZE:0] FULL_CNT = (SIZE + 1)'(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   fifo_addr_t       wr_ptr;
   fifo_addr_t       rd_ptr;
   logic [SIZE:0]    count;
   logic             full;
   logic             wr_en;
   logic             rd_en;

   // Pointers wrap at the configured depth.
   function automatic fifo_addr_t next_ptr(input fifo_addr_t ptr);
      return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
   endfunction

   assign full     = (count == FULL_CNT);
   assign o_tready = ~full;
   assign o_tvalid = (count != '0);
   assign o_tdata  = mem[rd_ptr];
   assign wr_en    = i_tvalid & o_tready;
   assign rd_en    = o_tvalid & i_tready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= next_ptr(wr_ptr);
         if (rd_en)
            rd_ptr <= next_ptr(rd_ptr);
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage only.
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= i_tdata;
   end

   // A write into a full FIFO would push the occupancy past the depth.
   a_no_write_full: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      (count <= FULL_CNT) && (fifo_addr_t'(wr_ptr - rd_ptr) == fifo_addr_t'(count)))
      else $error("axi_fifo: occupancy out of step with the pointers");

endmodule

/* src/axi_packet_gate.sv */
// Packet hold and drop gate
`timescale 1ns/1ns
`include "pkt_rx_macros.svh"

module axi_packet_gate (
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_clear,
   input  pkt_stream_pkg::pkt_data_t i_tdata,
   input  logic                      i_tlast,
   input  logic                      i_terror,
   input  logic                      i_tvalid,
   output logic                      o_tready,
   output pkt_stream_pkg::pkt_data_t o_tdata,
   output logic                      o_tlast,
   output logic                      o_tvalid,
   input  logic                      i_tready,
   output pkt_stream_pkg::pkt_cnt_t  o_held_pkts,
   output logic                      o_pkt_commit,
   output logic                      o_pkt_drop
);
   import pkt_stream_pkg::*;

   localparam pkt_cnt_t CNT_MAX = '1;

   pkt_cnt_t num_pkts;
   logic     dump;
   logic     in_open;
   logic     out_open;
   logic     fifo_in_valid;
   logic     fifo_in_ready;
   logic     fifo_out_valid;
   logic     fifo_out_ready;
   logic     fifo_clear;
   logic     last_in;
   logic     last_out;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Gating of both sides
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Input closes while dumping or when the packet count is saturated.
   assign in_open       = ~dump & (num_pkts != CNT_MAX);
   assign fifo_in_valid = in_open & i_tvalid;
   assign o_tready      = in_open & fifo_in_ready;

   // Output opens only once a whole packet sits in the FIFO.
   assign out_open       = (num_pkts != '0);
   assign o_tvalid       = out_open & fifo_out_valid;
   assign fifo_out_ready = out_open & i_tready;

   assign last_in  = fifo_in_valid & fifo_in_ready & i_tlast;
   assign last_out = fifo_out_valid & fifo_out_ready & o_tlast;

   assign o_held_pkts  = num_pkts;
   assign o_pkt_commit = last_out;
   assign o_pkt_drop   = last_in & i_terror;

   // Counted packets are gone, so the partial rest is thrown away.
   assign fifo_clear = i_clear | (dump & (num_pkts == '0));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Packet count and dump state
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         num_pkts <= '0;
         dump     <= 1'b0;
      end
      else if (dump)
      begin
         // Drain what was complete before the bad frame.
         if (num_pkts == '0)
            dump <= 1'b0;
         else if (last_out)
            num_pkts <= num_pkts - 1'b1;
      end
      else if (last_in && i_terror)
      begin
         dump <= 1'b1;
         if (last_out)
            num_pkts <= num_pkts - 1'b1;
      end
      else if (last_in && !last_out)
         num_pkts <= num_pkts + 1'b1;
      else if (!last_in && last_out)
         num_pkts <= num_pkts - 1'b1;
   end

   axi_fifo #(
      .WIDTH (`PKT_DATA_W + 1),
      .SIZE  (`PKT_FIFO_AW)
   ) i_fifo (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_clear  (fifo_clear),
      .i_tdata  ({i_tlast, i_tdata}),
      .i_tvalid (fifo_in_valid),
      .o_tready (fifo_in_ready),
      .o_tdata  ({o_tlast, o_tdata}),
      .o_tvalid (fifo_out_valid),
      .i_tready (fifo_out_ready)
   );

   // The count never wraps in either direction.
   a_cnt_range: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      (num_pkts == CNT_MAX |=> num_pkts != '0) and
      (num_pkts == '0 |=> num_pkts != CNT_MAX))
      else $error("axi_packet_gate: packet count wrapped");

endmodule

/* src/pkt_csr_pkg.sv */
// Receive path register map
`include "pkt_rx_macros.svh"

package pkt_csr_pkg;

   // APB data word.
   typedef logic [31:0] csr_data_t;

   // Register offsets, one word apart.
   typedef enum logic [`CSR_ADDR_W-1:0] {
      REG_CTRL   = 4'h0,
      REG_STATUS = 4'h4,
      REG_GOOD   = 4'h8,
      REG_DROP   = 4'hC
   } csr_reg_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Control register fields
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Enable, resets to 1.
   localparam int CTRL_EN_BIT  = 0;
   // Soft clear, write 1 to fire, reads back 0.
   localparam int CTRL_CLR_BIT = 1;

endpackage

/* src/pkt_rx_macros.svh */
// Packet receive path widths
`ifndef PKT_RX_MACROS_SVH
`define PKT_RX_MACROS_SVH

// Width of one stream data beat.
`define PKT_DATA_W 32

// FIFO address width, 64 entries.
`define PKT_FIFO_AW 6

// Held-packet count width. The gate stops at the all-ones value.
`define PKT_CNT_W 8

// APB byte address width for the register block.
`define CSR_ADDR_W 4

`endif

/* src/pkt_rx_top.sv */
// Packet receive path top
`timescale 1ns/1ns
`include "pkt_rx_macros.svh"

module pkt_rx_top (
   input  logic                      clk,
   input  logic                      i_rst,
   // Stream from the network interface.
   input  pkt_stream_pkg::pkt_data_t i_tdata,
   input  logic                      i_tlast,
   input  logic                      i_terror,
   input  logic                      i_tvalid,
   output logic                      o_tready,
   // Stream of whole, good frames.
   output pkt_stream_pkg::pkt_data_t o_tdata,
   output logic                      o_tlast,
   output logic                      o_tvalid,
   input  logic                      i_out_tready,
   // APB register port.
   input  logic                      i_psel,
   input  logic                      i_penable,
   input  logic                      i_pwrite,
   input  logic [`CSR_ADDR_W-1:0]    i_paddr,
   input  pkt_csr_pkg::csr_data_t    i_pwdata,
   output pkt_csr_pkg::csr_data_t    o_prdata,
   output logic                      o_pslverr
);
   import pkt_stream_pkg::*;

   pkt_data_t chk_tdata;
   logic      chk_tlast;
   logic      chk_bad;
   logic      chk_tvalid;
   logic      gate_tready;
   pkt_cnt_t  held_pkts;
   logic      pkt_commit;
   logic      pkt_drop;
   logic      enable;
   logic      clear;

   rx_frame_check i_check (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_clear  (clear),
      .i_enable (enable),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_terror (i_terror),
      .i_tvalid (i_tvalid),
      .o_tready (o_tready),
      .o_tdata  (chk_tdata),
      .o_tlast  (chk_tlast),
      .o_bad    (chk_bad),
      .o_tvalid (chk_tvalid),
      .i_tready (gate_tready)
   );

   axi_packet_gate i_gate (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_clear      (clear),
      .i_tdata      (chk_tdata),
      .i_tlast      (chk_tlast),
      .i_terror     (chk_bad),
      .i_tvalid     (chk_tvalid),
      .o_tready     (gate_tready),
      .o_tdata      (o_tdata),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_tready     (i_out_tready),
      .o_held_pkts  (held_pkts),
      .o_pkt_commit (pkt_commit),
      .o_pkt_drop   (pkt_drop)
   );

   rx_csr_apb i_csr (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pslverr    (o_pslverr),
      .i_held_pkts  (held_pkts),
      .i_pkt_commit (pkt_commit),
      .i_pkt_drop   (pkt_drop),
      .o_enable     (enable),
      .o_clear      (clear)
   );

endmodule

/* src/pkt_stream_pkg.sv */
// Stream datapath types
`include "pkt_rx_macros.svh"

package pkt_stream_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Beat and bookkeeping types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // One data beat on the stream.
   typedef logic [`PKT_DATA_W-1:0] pkt_data_t;

   // Number of complete packets held in the gate.
   typedef logic [`PKT_CNT_W-1:0] pkt_cnt_t;

   // Read and write pointers of the packet FIFO.
   typedef logic [`PKT_FIFO_AW-1:0] fifo_addr_t;

endpackage

/* src/rx_csr_apb.sv */
// APB control and status registers
`timescale 1ns/1ns
`include "pkt_rx_macros.svh"

module rx_csr_apb (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic                     i_psel,
   input  logic                     i_penable,
   input  logic                     i_pwrite,
   input  logic [`CSR_ADDR_W-1:0]   i_paddr,
   input  pkt_csr_pkg::csr_data_t   i_pwdata,
   output pkt_csr_pkg::csr_data_t   o_prdata,
   output logic                     o_pslverr,
   input  pkt_stream_pkg::pkt_cnt_t i_held_pkts,
   input  logic                     i_pkt_commit,
   input  logic                     i_pkt_drop,
   output logic                     o_enable,
   output logic                     o_clear
);
   import pkt_csr_pkg::*;

   logic      access;
   logic      wr_ctrl;
   logic      addr_ok;
   logic      enable_q;
   logic      clear_q;
   csr_data_t good_cnt;
   csr_data_t drop_cnt;
   csr_data_t rd_data;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Access decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Zero wait states, so every access phase completes.
   assign access  = i_psel & i_penable;
   assign wr_ctrl = access & i_pwrite & (i_paddr == REG_CTRL);

   always_comb
   begin
      addr_ok = 1'b1;
      rd_data = '0;
      case (i_paddr)
         REG_CTRL:   rd_data[CTRL_EN_BIT] = enable_q;
         REG_STATUS: rd_data = csr_data_t'(i_held_pkts);
         REG_GOOD:   rd_data = good_cnt;
         REG_DROP:   rd_data = drop_cnt;
         default:    addr_ok = 1'b0;
      endcase
   end

   // Unmapped offsets answer with an error and zero data.
   assign o_prdata  = (access && !i_pwrite) ? rd_data : '0;
   assign o_pslverr = access & ~addr_ok;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Control register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         enable_q <= 1'b1;
         clear_q  <= 1'b0;
      end
      else
      begin
         if (wr_ctrl)
            enable_q <= i_pwdata[CTRL_EN_BIT];
         // Self-clearing, one cycle wide.
         clear_q <= wr_ctrl & i_pwdata[CTRL_CLR_BIT];
      end
   end

   assign o_enable = enable_q;
   assign o_clear  = clear_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Event counters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk)
   begin
      if (i_rst || clear_q)
      begin
         good_cnt <= '0;
         drop_cnt <= '0;
      end
      else
      begin
         if (i_pkt_commit)
            good_cnt <= good_cnt + 1'b1;
         if (i_pkt_drop)
            drop_cnt <= drop_cnt + 1'b1;
      end
   end

   // Access phase always follows a setup phase with psel held.
   a_penable_psel: assert property (@(posedge clk) disable iff (i_rst)
      i_penable |-> i_psel && $past(i_psel))
      else $error("rx_csr_apb: penable without psel");

endmodule

/* src/rx_frame_check.sv */
// Frame checksum stage
`timescale 1ns/1ns

module rx_frame_check (
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_clear,
   input  logic                      i_enable,
   input  pkt_stream_pkg::pkt_data_t i_tdata,
   input  logic                      i_tlast,
   input  logic                      i_terror,
   input  logic                      i_tvalid,
   output logic                      o_tready,
   output pkt_stream_pkg::pkt_data_t o_tdata,
   output logic                      o_tlast,
   output logic                      o_bad,
   output logic                      o_tvalid,
   input  logic                      i_tready
);
   import pkt_stream_pkg::*;

   // XOR of the accepted beats before the last one.
   pkt_data_t csum;
   logic      beat_in;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake pass-through with enable
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Disabled: nothing enters, nothing is offered downstream.
   assign o_tvalid = i_tvalid & i_enable;
   assign o_tready = i_tready & i_enable;
   assign o_tdata  = i_tdata;
   assign o_tlast  = i_tlast;

   assign beat_in = i_tvalid & o_tready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Running checksum
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The last beat carries the expected sum; only checked there.
   assign o_bad = i_terror | (i_tdata != csum);

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
         csum <= '0;
      else if (beat_in)
      begin
         if (i_tlast)
            csum <= '0;
         else
            csum <= csum ^ i_tdata;
      end
   end

   // Source holds a stalled beat until it transfers.
   a_stall_stable: assert property (@(posedge clk) disable iff (i_rst)
      i_tvalid && !o_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tlast))
      else $error("rx_frame_check: input beat changed while stalled");

endmodule

/* testbench/tb_pkt_rx_top.sv */
// Packet receive path testbench
`timescale 1ns/1ns
`include "pkt_rx_macros.svh"

module tb_pkt_rx_top;
   import pkt_stream_pkg::*;
   import pkt_csr_pkg::*;

   localparam int          N_RANDOM        = 80;
   localparam int          N_FRAMES        = N_RANDOM + 6;
   localparam int          WATCHDOG_CYCLES = N_FRAMES * 40 + 2000;
   localparam logic [31:0] SEED            = 32'h2477de1f;

   logic                   clk = 1'b0;
   logic                   i_rst;
   pkt_data_t              i_tdata;
   logic                   i_tlast;
   logic                   i_terror;
   logic                   i_tvalid;
   logic                   o_tready;
   pkt_data_t              o_tdata;
   logic                   o_tlast;
   logic                   o_tvalid;
   logic                   i_out_tready = 1'b1;
   logic                   i_psel;
   logic                   i_penable;
   logic                   i_pwrite;
   logic [`CSR_ADDR_W-1:0] i_paddr;
   csr_data_t              i_pwdata;
   csr_data_t              o_prdata;
   logic                   o_pslverr;

   // Frames in flight at the input, and beats expected at the output.
   logic [32:0] pend_q[$];
   logic        pend_bad[$];
   logic [32:0] exp_q[$];
   logic [32:0] model_beat;
   logic        model_bad;
   pkt_data_t   exp_data    = '0;
   logic        exp_last    = 1'b0;
   logic        exp_avail   = 1'b0;
   int          good_exp    = 0;
   int          sent_bad    = 0;
   logic        in_acc      = 1'b0;
   logic        in_last_acc = 1'b0;
   logic        out_acc     = 1'b0;
   logic        en_model    = 1'b1;
   logic        in_clear    = 1'b0;
   logic        stall_on    = 1'b0;
   logic        out_hold    = 1'b0;
   logic        rd_check    = 1'b0;
   csr_data_t   rd_exp      = '0;
   logic        rd_err_exp  = 1'b0;
   logic [31:0] frame_rng   = SEED;
   logic [31:0] stall_rng   = ~SEED;

   pkt_rx_top i_dut (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_tdata      (i_tdata),
      .i_tlast      (i_tlast),
      .i_terror     (i_terror),
      .i_tvalid     (i_tvalid),
      .o_tready     (o_tready),
      .o_tdata      (o_tdata),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_out_tready (i_out_tready),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pslverr    (o_pslverr)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "Run stopped at the first error.");
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Handshakes seen at each edge are consumed on the following falling edge.
   always @(posedge clk)
   begin
      in_acc      <= !i_rst && i_tvalid && o_tready;
      in_last_acc <= !i_rst && i_tvalid && o_tready && i_tlast;
      out_acc     <= !i_rst && o_tvalid && i_out_tready;
   end

   always @(negedge clk)
   begin
      // A whole frame has entered; good ones become expected output.
      if (in_last_acc)
      begin
         model_bad  = pend_bad.pop_front();
         model_beat = '0;
         while (!model_beat[32] && pend_q.size() != 0)
         begin
            model_beat = pend_q.pop_front();
            if (!model_bad)
               exp_q.push_back(model_beat);
         end
         if (!model_bad)
            good_exp++;
      end
      if (in_clear)
      begin
         exp_q.delete();
         good_exp = 0;
      end
      else if (out_acc && exp_q.size() != 0)
         model_beat = exp_q.pop_front();
      exp_avail = (exp_q.size() != 0);
      if (exp_avail)
      begin
         exp_data = exp_q[0][31:0];
         exp_last = exp_q[0][32];
      end
   end

   // Output back-pressure.
   always @(negedge clk)
   begin
      stall_rng = xorshift32(stall_rng);
      if (out_hold)
         i_out_tready = 1'b0;
      else if (stall_on)
         i_out_tready = (stall_rng[2:0] > 3'd1);
      else
         i_out_tready = 1'b1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   a_out_data: assert property (@(posedge clk) disable iff (i_rst || in_clear)
      o_tvalid && exp_avail |-> o_tdata == exp_data)
      else report_value("o_tdata", $sampled(o_tdata), exp_data);

   a_out_last: assert property (@(posedge clk) disable iff (i_rst || in_clear)
      o_tvalid && exp_avail |-> o_tlast == exp_last)
      else report_value("o_tlast", 32'($sampled(o_tlast)), 32'(exp_last));

   // Nothing leaves before its frame has fully entered.
   a_out_early: assert property (@(posedge clk) disable iff (i_rst || in_clear)
      o_tvalid |-> exp_avail)
      else report_value("o_tvalid", 32'd1, 32'd0);

   a_out_hold: assert property (@(posedge clk) disable iff (i_rst || in_clear)
      o_tvalid && !i_out_tready |=> o_tvalid)
      else report_value("o_tvalid", 32'd0, 32'd1);

   a_in_disabled: assert property (@(posedge clk) disable iff (i_rst)
      !en_model |-> !o_tready)
      else report_value("o_tready", 32'd1, 32'd0);

   a_rd_data: assert property (@(posedge clk) disable iff (i_rst)
      rd_check && i_psel && i_penable |-> o_prdata == rd_exp)
      else report_value("o_prdata", $sampled(o_prdata), rd_exp);

   a_rd_err: assert property (@(posedge clk) disable iff (i_rst)
      rd_check && i_psel && i_penable |-> o_pslverr == rd_err_exp)
      else report_value("o_pslverr", 32'($sampled(o_pslverr)), 32'(rd_err_exp));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Kind 0 is good, 1 has a wrong checksum, 2 raises the error input on the last beat.
   task automatic send_frame(input int len, input int kind);
      logic [32:0] beats[$];
      pkt_data_t   csum;
      pkt_data_t   word;
      int          i;
      csum = '0;
      for (i = 0; i < len - 1; i++)
      begin
         frame_rng = xorshift32(frame_rng);
         word      = frame_rng;
         csum      = csum ^ word;
         beats.push_back({1'b0, word});
      end
      frame_rng = xorshift32(frame_rng);
      word      = (kind == 1) ? (csum ^ (frame_rng | 32'h1)) : csum;
      beats.push_back({1'b1, word});
      for (i = 0; i < len; i++)
         pend_q.push_back(beats[i]);
      pend_bad.push_back(kind != 0);
      for (i = 0; i < len; i++)
      begin
         i_tvalid = 1'b1;
         i_tdata  = beats[i][31:0];
         i_tlast  = beats[i][32];
         i_terror = (kind == 2) && beats[i][32];
         @(negedge clk);
         while (!in_acc)
            @(negedge clk);
      end
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
      i_terror = 1'b0;
   endtask

   task automatic wait_output_idle();
      @(posedge clk);
      while (exp_avail || pend_q.size() != 0)
         @(posedge clk);
      @(negedge clk);
   endtask

   task automatic apb_write(input logic [`CSR_ADDR_W-1:0] addr, input csr_data_t data);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b1;
      i_paddr   = addr;
      i_pwdata  = data;
      @(negedge clk);
      i_penable = 1'b1;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      if (addr == REG_CTRL)
         en_model = data[CTRL_EN_BIT];
   endtask

   task automatic apb_read_check(input logic [`CSR_ADDR_W-1:0] addr, input csr_data_t data,
                                 input logic err);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = addr;
      @(negedge clk);
      i_penable  = 1'b1;
      rd_check   = 1'b1;
      rd_exp     = data;
      rd_err_exp = err;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      rd_check  = 1'b0;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin : main
      int n;
      int len;
      int kind;
      i_rst     = 1'b1;
      i_tdata   = '0;
      i_tlast   = 1'b0;
      i_terror  = 1'b0;
      i_tvalid  = 1'b0;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      repeat (5) @(negedge clk);
      i_rst = 1'b0;
      @(negedge clk);

      // Reset value of the control register and an unmapped offset.
      apb_read_check(REG_CTRL, 32'h1, 1'b0);
      apb_read_check(4'h2, 32'h0, 1'b1);

      // Random frames under back-pressure. Bad frames wait for an idle output.
      stall_on = 1'b1;
      for (n = 0; n < N_RANDOM; n++)
      begin
         frame_rng = xorshift32(frame_rng);
         len       = (frame_rng[7:0] % 12) + 1;
         kind      = (frame_rng[10:8] != 3'd0) ? 0 : (frame_rng[11] ? 1 : 2);
         if (kind != 0)
         begin
            wait_output_idle();
            sent_bad++;
         end
         send_frame(len, kind);
      end
      wait_output_idle();
      stall_on = 1'b0;
      apb_read_check(REG_GOOD, csr_data_t'(good_exp), 1'b0);
      apb_read_check(REG_DROP, csr_data_t'(sent_bad), 1'b0);
      apb_read_check(REG_STATUS, 32'h0, 1'b0);

      // Input held off while disabled, then accepted once enabled again.
      apb_write(REG_CTRL, 32'h0);
      fork
         send_frame(4, 0);
         begin
            repeat (10) @(negedge clk);
            apb_write(REG_CTRL, 32'h1);
         end
      join
      wait_output_idle();
      apb_read_check(REG_CTRL, 32'h1, 1'b0);

      // Soft clear with frames stuck behind a stalled output.
      out_hold = 1'b1;
      send_frame(5, 0);
      send_frame(3, 0);
      send_frame(7, 0);
      apb_read_check(REG_STATUS, 32'd3, 1'b0);
      in_clear = 1'b1;
      apb_write(REG_CTRL, 32'h3);
      repeat (3) @(negedge clk);
      in_clear = 1'b0;
      sent_bad = 0;
      apb_read_check(REG_STATUS, 32'h0, 1'b0);
      apb_read_check(REG_GOOD, 32'h0, 1'b0);
      apb_read_check(REG_DROP, 32'h0, 1'b0);
      apb_read_check(REG_CTRL, 32'h1, 1'b0);
      out_hold = 1'b0;

      // The path still works after a clear.
      send_frame(2, 0);
      send_frame(1, 0);
      wait_output_idle();
      apb_read_check(REG_GOOD, 32'd2, 1'b0);

      $display("Verification passed");
      $finish;
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
      $display("Verification failed");
      $fatal(1, "Watchdog expired.");
   end

endmodule
